//--- common/core_params.svh
// core parameters: data, register address and shift amount widths
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// data path width
`define XLEN 64

// register index width, 32 registers
`define REG_ADDR_W 5

// shift amount width, covers 0..63
`define SHAMT_W 6

`endif

//--- common/core_pkg.sv
// core types: alu opcodes, execute states and the packets between stages
`include "core_params.svh"

package core_pkg;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLT  = 4'd2,
    ALU_SLTU = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_OR   = 4'd5,
    ALU_AND  = 4'd6,
    ALU_SLL  = 4'd7,
    ALU_SRL  = 4'd8,
    ALU_SRA  = 4'd9
  } alu_op_e;

  typedef enum logic [1:0] {
    EX_IDLE  = 2'd0,
    EX_SHIFT = 2'd1,
    EX_HOLD  = 2'd2
  } ex_state_e;

  // what fetch hands to decode
  typedef struct packed {
    logic [31:0]      inst;
    logic [`XLEN-1:0] pc;
  } fetch_pkt_t;

  // decoded instruction, operands already selected
  typedef struct packed {
    logic [`XLEN-1:0]       pc;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   wen;
    alu_op_e                alu_op;
    logic                   is_word;
    logic                   illegal;
    logic [`XLEN-1:0]       op1;
    logic [`XLEN-1:0]       op2;
  } id_ex_t;

  // retired result, also the register file write
  typedef struct packed {
    logic [`XLEN-1:0]       pc;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   wen;
    logic [`XLEN-1:0]       value;
    logic                   illegal;
  } retire_t;

endpackage

//--- hw/regfile.sv
// register file: 32 x 64-bit, two combinational reads, one write, x0 reads zero
`include "core_params.svh"

module regfile (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`REG_ADDR_W-1:0] rs1_addr,
  input  logic [`REG_ADDR_W-1:0] rs2_addr,
  output logic [`XLEN-1:0]       rs1_data,
  output logic [`XLEN-1:0]       rs2_data,
  input  logic                   wr_en,
  input  logic [`REG_ADDR_W-1:0] wr_addr,
  input  logic [`XLEN-1:0]       wr_data
);

  localparam int NUM_REGS = 1 << `REG_ADDR_W;

  logic [`XLEN-1:0] regs [NUM_REGS];

  // x0 is never written so it keeps its reset value
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

endmodule

//--- hw/decode/id_stage.sv
// decode stage: fetch register, hazard stall, operand select and alu opcode decode
`include "core_params.svh"

module id_stage (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   fetch_valid,
  input  core_pkg::fetch_pkt_t   fetch_pkt,
  output logic                   fetch_allowin,
  output logic                   id_to_ex_valid,
  output core_pkg::id_ex_t       id_to_ex,
  input  logic                   ex_allowin,
  output logic [`REG_ADDR_W-1:0] rs1_addr,
  output logic [`REG_ADDR_W-1:0] rs2_addr,
  input  logic [`XLEN-1:0]       rs1_data,
  input  logic [`XLEN-1:0]       rs2_data,
  input  logic [`REG_ADDR_W-1:0] ex_busy_rd
);
  import core_pkg::*;

  localparam logic [6:0] OPC_OP_IMM    = 7'h13;
  localparam logic [6:0] OPC_AUIPC     = 7'h17;
  localparam logic [6:0] OPC_OP_IMM_32 = 7'h1b;
  localparam logic [6:0] OPC_OP        = 7'h33;
  localparam logic [6:0] OPC_LUI       = 7'h37;
  localparam logic [6:0] OPC_OP_32     = 7'h3b;

  logic                   id_valid;
  logic                   ready_go;
  fetch_pkt_t             pkt_r;
  logic [31:0]            inst;
  logic [6:0]             opcode;
  logic [2:0]             func3;
  logic [6:0]             func7;
  logic [`REG_ADDR_W-1:0] rd;
  logic [`XLEN-1:0]       imm_i;
  logic [`XLEN-1:0]       imm_u;
  logic                   reg_form;
  logic                   alt;
  logic                   f7_ok_reg;
  logic                   f6_ok_imm;
  logic                   f7_ok_immw;
  logic                   word_f3;
  alu_op_e                base_op;
  alu_op_e                alu_op;
  logic                   legal;
  logic                   use_rs1;
  logic                   use_rs2;
  logic                   is_word;
  logic [`XLEN-1:0]       op1;
  logic [`XLEN-1:0]       op2;
  logic                   hazard;

  // valid/allowin bookkeeping
  assign fetch_allowin  = !id_valid || (ready_go && ex_allowin);
  assign id_to_ex_valid = id_valid && ready_go;

  always_ff @(posedge clk) begin
    if (rst) begin
      id_valid <= 1'b0;
    end else if (fetch_allowin) begin
      id_valid <= fetch_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_valid && fetch_allowin) begin
      pkt_r <= fetch_pkt;
    end
  end

  assign inst     = pkt_r.inst;
  assign opcode   = inst[6:0];
  assign func3    = inst[14:12];
  assign func7    = inst[31:25];
  assign rd       = inst[11:7];
  assign rs1_addr = inst[19:15];
  assign rs2_addr = inst[24:20];
  assign imm_i    = {{(`XLEN-12){inst[31]}}, inst[31:20]};
  assign imm_u    = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};

  // bit 30 picks sub/sra, but for immediates only on the shift-right slot
  assign reg_form   = (opcode == OPC_OP) || (opcode == OPC_OP_32);
  assign alt        = inst[30] && (reg_form || func3 == 3'd5);
  assign f7_ok_reg  = (func7 == 7'h00) ||
                      (func7 == 7'h20 && (func3 == 3'd0 || func3 == 3'd5));
  assign f6_ok_imm  = (func3 == 3'd1) ? (inst[31:26] == 6'h00) :
                      (func3 == 3'd5) ? (inst[31:26] == 6'h00 || inst[31:26] == 6'h10) :
                      1'b1;
  assign f7_ok_immw = (func3 == 3'd1) ? (func7 == 7'h00) :
                      (func3 == 3'd5) ? (func7 == 7'h00 || func7 == 7'h20) :
                      1'b1;
  assign word_f3    = (func3 == 3'd0) || (func3 == 3'd1) || (func3 == 3'd5);

  always_comb begin
    case (func3)
      3'd0:    base_op = alt ? ALU_SUB : ALU_ADD;
      3'd1:    base_op = ALU_SLL;
      3'd2:    base_op = ALU_SLT;
      3'd3:    base_op = ALU_SLTU;
      3'd4:    base_op = ALU_XOR;
      3'd5:    base_op = alt ? ALU_SRA : ALU_SRL;
      3'd6:    base_op = ALU_OR;
      default: base_op = ALU_AND;
    endcase
  end

  always_comb begin
    alu_op  = ALU_ADD;
    legal   = 1'b0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    is_word = 1'b0;
    op1     = rs1_data;
    op2     = imm_i;
    case (opcode)
      OPC_OP_IMM: begin
        alu_op  = base_op;
        legal   = f6_ok_imm;
        use_rs1 = 1'b1;
      end
      OPC_OP_IMM_32: begin
        alu_op  = base_op;
        legal   = word_f3 && f7_ok_immw;
        use_rs1 = 1'b1;
        is_word = 1'b1;
      end
      OPC_OP, OPC_OP_32: begin
        alu_op  = base_op;
        is_word = (opcode == OPC_OP_32);
        legal   = f7_ok_reg && (!is_word || word_f3);
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        op2     = rs2_data;
      end
      OPC_LUI: begin
        legal = 1'b1;
        op1   = '0;
        op2   = imm_u;
      end
      OPC_AUIPC: begin
        legal = 1'b1;
        op1   = pkt_r.pc;
        op2   = imm_u;
      end
      default: legal = 1'b0;
    endcase
  end

  // stall while execute still owes a result to one of our sources
  assign hazard = (ex_busy_rd != '0) &&
                  ((use_rs1 && rs1_addr == ex_busy_rd) ||
                   (use_rs2 && rs2_addr == ex_busy_rd));
  assign ready_go = !hazard;

  always_comb begin
    id_to_ex.pc      = pkt_r.pc;
    id_to_ex.rd      = rd;
    id_to_ex.wen     = legal && (rd != '0);
    id_to_ex.alu_op  = alu_op;
    id_to_ex.is_word = is_word;
    id_to_ex.illegal = !legal;
    id_to_ex.op1     = op1;
    id_to_ex.op2     = op2;
  end

endmodule

//--- hw/execute/shift_counter.sv
// shift counter: counts remaining shift steps down and flags zero
`include "core_params.svh"

module shift_counter (
  input  logic                clk,
  input  logic                rst,
  input  logic                load,
  input  logic                step,
  input  logic [`SHAMT_W-1:0] amount,
  output logic                done
);

  logic [`SHAMT_W-1:0] count;
  logic [`SHAMT_W-1:0] count_next;

  always_comb begin
    if (load) begin
      count_next = amount;
    end else if (step && count != '0) begin
      count_next = count - 1'b1;
    end else begin
      count_next = count;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else begin
      count <= count_next;
    end
  end

  // looks one step ahead, so the last shift and the hand-off share a cycle
  assign done = (count_next == '0);

endmodule

//--- hw/execute/ex_sequencer.sv
// execute sequencer: accept, serial shift and retire hold
module ex_sequencer (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_fire,
  input  logic                is_shift,
  input  logic                shift_done,
  input  logic                retire_ready,
  output core_pkg::ex_state_e state,
  output logic                ex_allowin,
  output logic                retire_valid,
  output logic                shift_step,
  output logic                load_count
);
  import core_pkg::*;

  ex_state_e state_next;

  // a new packet may enter as the held one leaves
  assign ex_allowin   = (state == EX_IDLE) || (state == EX_HOLD && retire_ready);
  assign retire_valid = (state == EX_HOLD);
  assign shift_step   = (state == EX_SHIFT);
  assign load_count   = in_fire && is_shift;

  always_comb begin
    state_next = state;
    case (state)
      EX_SHIFT: begin
        if (shift_done) begin
          state_next = EX_HOLD;
        end
      end
      EX_HOLD: begin
        if (retire_ready) begin
          state_next = EX_IDLE;
        end
      end
      default: state_next = EX_IDLE;
    endcase
    // zero-length shift goes straight to hold
    if (in_fire) begin
      state_next = (is_shift && !shift_done) ? EX_SHIFT : EX_HOLD;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= EX_IDLE;
    end else begin
      state <= state_next;
    end
  end

endmodule

//--- hw/execute/ex_stage.sv
// execute stage: one-cycle alu, bit-serial shifter and retire record
`include "core_params.svh"

module ex_stage (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   id_to_ex_valid,
  input  core_pkg::id_ex_t       id_to_ex,
  output logic                   ex_allowin,
  output logic                   retire_valid,
  output core_pkg::retire_t      retire,
  input  logic                   retire_ready,
  output logic [`REG_ADDR_W-1:0] ex_busy_rd
);
  import core_pkg::*;

  ex_state_e              state;
  logic                   in_fire;
  logic                   is_shift;
  logic                   shift_done;
  logic                   shift_step;
  logic                   load_count;
  logic [`SHAMT_W-1:0]    amount;
  logic [`XLEN-1:0]       op1;
  logic [`XLEN-1:0]       op2;
  logic [`XLEN-1:0]       alu_res;
  logic [`XLEN-1:0]       work;
  logic [`XLEN-1:0]       pc_r;
  logic [`REG_ADDR_W-1:0] rd_r;
  logic                   wen_r;
  alu_op_e                alu_op_r;
  logic                   is_word_r;
  logic                   illegal_r;

  assign in_fire  = id_to_ex_valid && ex_allowin;
  assign op1      = id_to_ex.op1;
  assign op2      = id_to_ex.op2;
  assign is_shift = (id_to_ex.alu_op == ALU_SLL) || (id_to_ex.alu_op == ALU_SRL) ||
                    (id_to_ex.alu_op == ALU_SRA);
  assign amount   = id_to_ex.is_word ? {1'b0, op2[4:0]} : op2[`SHAMT_W-1:0];

  ex_sequencer u_seq (
    .clk          (clk),
    .rst          (rst),
    .in_fire      (in_fire),
    .is_shift     (is_shift),
    .shift_done   (shift_done),
    .retire_ready (retire_ready),
    .state        (state),
    .ex_allowin   (ex_allowin),
    .retire_valid (retire_valid),
    .shift_step   (shift_step),
    .load_count   (load_count)
  );

  shift_counter u_cnt (
    .clk    (clk),
    .rst    (rst),
    .load   (load_count),
    .step   (shift_step),
    .amount (amount),
    .done   (shift_done)
  );

  // shifts load their starting word here, right shifts of words pre-extended
  always_comb begin
    case (id_to_ex.alu_op)
      ALU_SUB:  alu_res = op1 - op2;
      ALU_SLT:  alu_res = {{(`XLEN-1){1'b0}}, ($signed(op1) < $signed(op2))};
      ALU_SLTU: alu_res = {{(`XLEN-1){1'b0}}, (op1 < op2)};
      ALU_XOR:  alu_res = op1 ^ op2;
      ALU_OR:   alu_res = op1 | op2;
      ALU_AND:  alu_res = op1 & op2;
      ALU_SLL:  alu_res = op1;
      ALU_SRL:  alu_res = id_to_ex.is_word ? {{(`XLEN-32){1'b0}}, op1[31:0]} : op1;
      ALU_SRA:  alu_res = id_to_ex.is_word ? {{(`XLEN-32){op1[31]}}, op1[31:0]} : op1;
      default:  alu_res = op1 + op2;
    endcase
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      work <= alu_res;
    end else if (shift_step) begin
      case (alu_op_r)
        ALU_SLL: work <= {work[`XLEN-2:0], 1'b0};
        ALU_SRA: work <= {work[`XLEN-1], work[`XLEN-1:1]};
        default: work <= {1'b0, work[`XLEN-1:1]};
      endcase
    end
  end

  // operand register
  always_ff @(posedge clk) begin
    if (in_fire) begin
      pc_r      <= id_to_ex.pc;
      rd_r      <= id_to_ex.rd;
      wen_r     <= id_to_ex.wen;
      alu_op_r  <= id_to_ex.alu_op;
      is_word_r <= id_to_ex.is_word;
      illegal_r <= id_to_ex.illegal;
    end
  end

  assign ex_busy_rd = (state != EX_IDLE && wen_r) ? rd_r : '0;

  always_comb begin
    retire.pc      = pc_r;
    retire.rd      = rd_r;
    retire.wen     = wen_r;
    retire.value   = is_word_r ? {{(`XLEN-32){work[31]}}, work[31:0]} : work;
    retire.illegal = illegal_r;
  end

endmodule

//--- hw/core_top.sv
// core top: decode, register file and execute between fetch and retire ports
`include "core_params.svh"

module core_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 fetch_valid,
  input  core_pkg::fetch_pkt_t fetch_pkt,
  output logic                 fetch_allowin,
  output logic                 retire_valid,
  output core_pkg::retire_t    retire,
  input  logic                 retire_ready
);
  import core_pkg::*;

  logic                   id_to_ex_valid;
  id_ex_t                 id_to_ex;
  logic                   ex_allowin;
  logic [`REG_ADDR_W-1:0] rs1_addr;
  logic [`REG_ADDR_W-1:0] rs2_addr;
  logic [`XLEN-1:0]       rs1_data;
  logic [`XLEN-1:0]       rs2_data;
  logic [`REG_ADDR_W-1:0] ex_busy_rd;
  logic                   rf_wr_en;

  // write back on the retire handshake
  assign rf_wr_en = retire_valid && retire_ready && retire.wen;

  id_stage u_id (
    .clk            (clk),
    .rst            (rst),
    .fetch_valid    (fetch_valid),
    .fetch_pkt      (fetch_pkt),
    .fetch_allowin  (fetch_allowin),
    .id_to_ex_valid (id_to_ex_valid),
    .id_to_ex       (id_to_ex),
    .ex_allowin     (ex_allowin),
    .rs1_addr       (rs1_addr),
    .rs2_addr       (rs2_addr),
    .rs1_data       (rs1_data),
    .rs2_data       (rs2_data),
    .ex_busy_rd     (ex_busy_rd)
  );

  regfile u_rf (
    .clk      (clk),
    .rst      (rst),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr_en    (rf_wr_en),
    .wr_addr  (retire.rd),
    .wr_data  (retire.value)
  );

  ex_stage u_ex (
    .clk            (clk),
    .rst            (rst),
    .id_to_ex_valid (id_to_ex_valid),
    .id_to_ex       (id_to_ex),
    .ex_allowin     (ex_allowin),
    .retire_valid   (retire_valid),
    .retire         (retire),
    .retire_ready   (retire_ready),
    .ex_busy_rd     (ex_busy_rd)
  );

endmodule

//--- verification/core_tb_asserts.sv
// core assertions: retire hold under back-pressure and reset behavior of the ports
module core_tb_asserts (
  input logic              clk,
  input logic              rst,
  input logic              fetch_allowin,
  input logic              retire_valid,
  input logic              retire_ready,
  input core_pkg::retire_t retire
);
  timeunit 1ns;
  timeprecision 1ps;

  // a stalled retire keeps its record until it is taken
  retire_held_stable: assert property (
    @(posedge clk) disable iff (rst)
    retire_valid && !retire_ready |=> retire_valid && $stable(retire)
  ) else $error("retire record changed while retire_ready was low");

  allowin_after_reset: assert property (
    @(posedge clk) rst |=> fetch_allowin
  ) else $error("fetch_allowin is low right after reset");

  no_retire_in_reset: assert property (
    @(posedge clk) rst |=> !retire_valid
  ) else $error("retire_valid is high while in reset");

endmodule

bind core_top core_tb_asserts u_asserts (.*);

//--- verification/core_tb.sv
// core testbench: directed instruction programs checked against a reference model
module core_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import core_pkg::*;

  localparam logic [6:0] OPC_OP_IMM    = 7'h13;
  localparam logic [6:0] OPC_AUIPC     = 7'h17;
  localparam logic [6:0] OPC_OP_IMM_32 = 7'h1b;
  localparam logic [6:0] OPC_OP        = 7'h33;
  localparam logic [6:0] OPC_LUI       = 7'h37;
  localparam logic [6:0] OPC_OP_32     = 7'h3b;

  // 65 instructions, each at most 64 shift steps plus pipeline fill and hold
  localparam int WORST_CYCLES   = 65 * 70;
  localparam int TIMEOUT_CYCLES = 2 * WORST_CYCLES + 16 + 500;

  logic        clk = 1'b0;
  logic        rst;
  logic        fetch_valid;
  fetch_pkt_t  fetch_pkt;
  logic        fetch_allowin;
  logic        retire_valid;
  retire_t     retire;
  logic        retire_ready;

  logic [15:0] lfsr;
  logic [63:0] next_pc;
  logic [63:0] model_regs [32];
  logic [31:0] prog_inst [$];
  logic [63:0] prog_pc [$];
  logic [63:0] exp_pc [$];
  logic [4:0]  exp_rd [$];
  logic        exp_ill [$];
  logic [63:0] exp_val [$];
  int          error_count = 0;
  int          cycle_count = 0;

  core_top dut0 (
    .clk           (clk),
    .rst           (rst),
    .fetch_valid   (fetch_valid),
    .fetch_pkt     (fetch_pkt),
    .fetch_allowin (fetch_allowin),
    .retire_valid  (retire_valid),
    .retire        (retire),
    .retire_ready  (retire_ready)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, a retire never arrived", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $fatal(1);
    end
  end

  task automatic check_value(input string test, input string what,
                             input logic [63:0] expected, input logic [63:0] actual);
    if (expected !== actual) begin
      error_count++;
      $display("Error %s %s expected %h actual %h", test, what, expected, actual);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  // 16-bit fibonacci lfsr, taps 16 14 13 11
  function automatic logic lfsr_step();
    logic fb;
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [11:0] lfsr_bits(input int n);
    logic [11:0] r;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
      r = {r[10:0], lfsr_step()};
    end
    return r;
  endfunction

  // RV64I semantics from the spec, returns {illegal, value}
  function automatic logic [64:0] model_exec(input logic [31:0] inst, input logic [63:0] pc);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic        reg_op;
    logic        word;
    logic        ok;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] r;
    logic [5:0]  sh;
    logic [63:0] upper;
    opc    = inst[6:0];
    f3     = inst[14:12];
    reg_op = (opc == OPC_OP) || (opc == OPC_OP_32);
    word   = (opc == OPC_OP_32) || (opc == OPC_OP_IMM_32);
    a      = model_regs[inst[19:15]];
    b      = reg_op ? model_regs[inst[24:20]] : {{52{inst[31]}}, inst[31:20]};
    sh     = word ? {1'b0, b[4:0]} : b[5:0];
    upper  = {{32{inst[31]}}, inst[31:12], 12'h000};
    case (opc)
      OPC_OP_IMM:    ok = (f3 != 3'd1 && f3 != 3'd5) ||
                          (!inst[31] && inst[29:26] == 4'd0 && (!inst[30] || f3 == 3'd5));
      OPC_OP_IMM_32: ok = (f3 == 3'd0) || ((f3 == 3'd1 || f3 == 3'd5) &&
                          !inst[31] && inst[29:25] == 5'd0 && (!inst[30] || f3 == 3'd5));
      OPC_OP:        ok = !inst[31] && inst[29:25] == 5'd0 &&
                          (!inst[30] || f3 == 3'd0 || f3 == 3'd5);
      OPC_OP_32:     ok = !inst[31] && inst[29:25] == 5'd0 &&
                          (!inst[30] || f3 == 3'd0 || f3 == 3'd5) &&
                          (f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5);
      OPC_LUI, OPC_AUIPC: ok = 1'b1;
      default:       ok = 1'b0;
    endcase
    case (f3)
      3'd0: r = (reg_op && inst[30]) ? a - b : a + b;
      3'd1: r = a << sh;
      3'd2: r = {63'd0, $signed(a) < $signed(b)};
      3'd3: r = {63'd0, a < b};
      3'd4: r = a ^ b;
      3'd5: begin
        // word right shifts start from the extended low half
        if (word) begin
          a = inst[30] ? {{32{a[31]}}, a[31:0]} : {32'd0, a[31:0]};
        end
        if (inst[30]) begin
          r = $signed(a) >>> sh;
        end else begin
          r = a >> sh;
        end
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    if (word) begin
      r = {{32{r[31]}}, r[31:0]};
    end
    if (opc == OPC_LUI) begin
      r = upper;
    end else if (opc == OPC_AUIPC) begin
      r = pc + upper;
    end
    return {!ok, r};
  endfunction

  task automatic queue_inst(input logic [31:0] inst);
    logic [64:0] res;
    res = model_exec(inst, next_pc);
    prog_inst.push_back(inst);
    prog_pc.push_back(next_pc);
    exp_pc.push_back(next_pc);
    exp_rd.push_back(inst[11:7]);
    exp_ill.push_back(res[64]);
    exp_val.push_back(res[63:0]);
    if (!res[64] && inst[11:7] != 5'd0) begin
      model_regs[inst[11:7]] = res[63:0];
    end
    next_pc = next_pc + 64'd4;
  endtask

  task automatic r_type_op(input logic [6:0] opc, input logic [2:0] f3, input logic [6:0] f7,
                           input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
    queue_inst({f7, rs2, rs1, f3, rd, opc});
  endtask

  task automatic imm_op(input logic [6:0] opc, input logic [2:0] f3, input logic [4:0] rd,
                        input logic [4:0] rs1, input logic [11:0] imm);
    queue_inst({imm, rs1, f3, rd, opc});
  endtask

  task automatic upper_op(input logic [6:0] opc, input logic [4:0] rd, input logic [19:0] imm);
    queue_inst({imm, rd, opc});
  endtask

  task automatic check_retire(input string test);
    check_value(test, "pc", exp_pc[0], retire.pc);
    check_value(test, "rd", 64'(exp_rd[0]), 64'(retire.rd));
    check_value(test, "illegal", 64'(exp_ill[0]), 64'(retire.illegal));
    check_value(test, "wen", 64'(!exp_ill[0] && exp_rd[0] != 5'd0), 64'(retire.wen));
    if (!exp_ill[0]) begin
      check_value(test, "value", exp_val[0], retire.value);
    end
    void'(exp_pc.pop_front());
    void'(exp_rd.pop_front());
    void'(exp_ill.pop_front());
    void'(exp_val.pop_front());
  endtask

  // offer the program at the fetch port, check each retire as it transfers
  task automatic run_prog(input string test, input logic random_ready);
    int   sent;
    logic fetch_fire;
    logic retire_fire;
    sent = 0;
    while (exp_pc.size() > 0) begin
      @(posedge clk);
      fetch_valid <= (sent < prog_inst.size());
      if (sent < prog_inst.size()) begin
        fetch_pkt.inst <= prog_inst[sent];
        fetch_pkt.pc   <= prog_pc[sent];
      end
      retire_ready <= random_ready ? lfsr_step() : 1'b1;
      @(negedge clk);
      fetch_fire  = fetch_valid && fetch_allowin;
      retire_fire = retire_valid && retire_ready;
      if (fetch_fire) begin
        sent++;
      end
      if (retire_fire) begin
        check_retire(test);
      end
    end
    prog_inst.delete();
    prog_pc.delete();
  endtask

  task automatic test_imm();
    imm_op(OPC_OP_IMM, 3'd0, 5'd1, 5'd0, 12'hffb);
    imm_op(OPC_OP_IMM, 3'd0, 5'd2, 5'd0, 12'h064);
    imm_op(OPC_OP_IMM, 3'd2, 5'd3, 5'd1, 12'hffd);
    imm_op(OPC_OP_IMM, 3'd3, 5'd4, 5'd1, 12'h005);
    imm_op(OPC_OP_IMM, 3'd4, 5'd5, 5'd2, 12'hfff);
    imm_op(OPC_OP_IMM, 3'd6, 5'd6, 5'd1, 12'h0f0);
    imm_op(OPC_OP_IMM, 3'd7, 5'd7, 5'd2, 12'h7e4);
    run_prog("imm", 1'b0);
  endtask

  task automatic test_chain();
    r_type_op(OPC_OP, 3'd0, 7'h00, 5'd8, 5'd1, 5'd2);
    r_type_op(OPC_OP, 3'd0, 7'h20, 5'd9, 5'd8, 5'd1);
    r_type_op(OPC_OP, 3'd2, 7'h00, 5'd10, 5'd1, 5'd9);
    r_type_op(OPC_OP, 3'd3, 7'h00, 5'd11, 5'd1, 5'd9);
    r_type_op(OPC_OP, 3'd4, 7'h00, 5'd12, 5'd11, 5'd8);
    r_type_op(OPC_OP, 3'd6, 7'h00, 5'd13, 5'd12, 5'd1);
    r_type_op(OPC_OP, 3'd7, 7'h00, 5'd14, 5'd13, 5'd9);
    run_prog("chain", 1'b0);
  endtask

  task automatic test_shift();
    upper_op(OPC_LUI, 5'd15, 20'h80000);
    imm_op(OPC_OP_IMM, 3'd0, 5'd15, 5'd15, 12'h123);
    imm_op(OPC_OP_IMM, 3'd0, 5'd16, 5'd0, 12'd31);
    imm_op(OPC_OP_IMM, 3'd0, 5'd17, 5'd0, 12'd63);
    imm_op(OPC_OP_IMM, 3'd0, 5'd18, 5'd0, 12'd1);
    imm_op(OPC_OP_IMM, 3'd1, 5'd19, 5'd15, 12'h000);
    imm_op(OPC_OP_IMM, 3'd1, 5'd20, 5'd15, 12'h001);
    imm_op(OPC_OP_IMM, 3'd5, 5'd21, 5'd15, 12'h01f);
    imm_op(OPC_OP_IMM, 3'd5, 5'd22, 5'd15, 12'h43f);
    r_type_op(OPC_OP, 3'd1, 7'h00, 5'd23, 5'd15, 5'd17);
    r_type_op(OPC_OP, 3'd5, 7'h00, 5'd24, 5'd15, 5'd18);
    r_type_op(OPC_OP, 3'd5, 7'h20, 5'd25, 5'd15, 5'd16);
    imm_op(OPC_OP_IMM_32, 3'd1, 5'd26, 5'd15, 12'h01f);
    imm_op(OPC_OP_IMM_32, 3'd5, 5'd27, 5'd15, 12'h001);
    imm_op(OPC_OP_IMM_32, 3'd5, 5'd28, 5'd15, 12'h41f);
    r_type_op(OPC_OP_32, 3'd1, 7'h00, 5'd29, 5'd15, 5'd18);
    r_type_op(OPC_OP_32, 3'd5, 7'h00, 5'd30, 5'd15, 5'd0);
    r_type_op(OPC_OP_32, 3'd5, 7'h20, 5'd31, 5'd15, 5'd17);
    run_prog("shift", 1'b0);
  endtask

  task automatic test_upper();
    upper_op(OPC_LUI, 5'd1, 20'h12345);
    upper_op(OPC_AUIPC, 5'd2, 20'hfffff);
    upper_op(OPC_AUIPC, 5'd3, 20'h00001);
    upper_op(OPC_LUI, 5'd5, 20'h7ffff);
    imm_op(OPC_OP_IMM, 3'd0, 5'd5, 5'd5, 12'h7ff);
    r_type_op(OPC_OP_32, 3'd0, 7'h00, 5'd6, 5'd5, 5'd5);
    upper_op(OPC_LUI, 5'd7, 20'h80000);
    imm_op(OPC_OP_IMM, 3'd0, 5'd4, 5'd0, 12'h001);
    r_type_op(OPC_OP_32, 3'd0, 7'h20, 5'd8, 5'd7, 5'd4);
    imm_op(OPC_OP_IMM_32, 3'd0, 5'd9, 5'd5, 12'h7ff);
    run_prog("upper", 1'b0);
  endtask

  task automatic test_backpressure();
    int          i;
    logic [11:0] imm;
    logic [11:0] amt;
    for (i = 0; i < 5; i++) begin
      imm = lfsr_bits(12);
      amt = lfsr_bits(6);
      imm_op(OPC_OP_IMM, 3'd0, 5'(10 + i), 5'(9 + i), imm);
      imm_op(OPC_OP_IMM, 3'd1, 5'd20, 5'(10 + i), {6'h00, amt[5:0]});
      r_type_op(OPC_OP, 3'd0, 7'h20, 5'd21, 5'd20, 5'(10 + i));
    end
    run_prog("backpressure", 1'b1);
  endtask

  task automatic test_illegal();
    imm_op(OPC_OP_IMM, 3'd0, 5'd9, 5'd0, 12'd77);
    queue_inst(32'h0000_0073);
    r_type_op(OPC_OP, 3'd0, 7'h01, 5'd9, 5'd1, 5'd2);
    imm_op(OPC_OP_IMM_32, 3'd2, 5'd9, 5'd1, 12'h000);
    queue_inst(32'h0000_0000);
    r_type_op(OPC_OP, 3'd0, 7'h00, 5'd10, 5'd9, 5'd0);
    imm_op(OPC_OP_IMM, 3'd0, 5'd0, 5'd0, 12'd5);
    r_type_op(OPC_OP, 3'd6, 7'h00, 5'd11, 5'd0, 5'd0);
    run_prog("illegal", 1'b0);
  endtask

  initial begin
    lfsr         = 16'd48;
    next_pc      = 64'h0000_0000_8000_0000;
    model_regs   = '{default: '0};
    rst          = 1'b1;
    fetch_valid  = 1'b0;
    fetch_pkt    = '0;
    retire_ready = 1'b1;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_value("reset", "fetch_allowin", 64'd1, 64'(fetch_allowin));
    check_value("reset", "retire_valid", 64'd0, 64'(retire_valid));
    test_imm();
    test_chain();
    test_shift();
    test_upper();
    test_backpressure();
    test_illegal();
    // nothing may retire once every program has drained
    @(posedge clk);
    retire_ready <= 1'b1;
    repeat (4) begin
      @(negedge clk);
      check_value("drain", "retire_valid", 64'd0, 64'(retire_valid));
    end
    if (error_count == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("TEST FAILED");
      $fatal(1);
    end
  end

endmodule

//--- compile.f
+incdir+common
common/core_pkg.sv
hw/regfile.sv
hw/decode/id_stage.sv
hw/execute/shift_counter.sv
hw/execute/ex_sequencer.sv
hw/execute/ex_stage.sv
hw/core_top.sv
verification/core_tb_asserts.sv
verification/core_tb.sv

//--- run.sh
#!/bin/sh
# build the core testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module core_tb -Mdir "$OBJ" -f compile.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"$OBJ/Vcore_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
exit 0
